//--- list.f
+incdir+.
nanoDecodePkg.sv
nanoBusDecode.sv
nanoFtuDecode.sv
nanoRegRoute.sv
nanoDecodeUnit.sv
nanoDecodeTb.sv

//--- nanoDecodeTb.sv
// Directed testbench for the nanocode decode stage with a reference model and watchdog
module nanoDecodeTb
	import nanoDecodePkg::*;
();

	localparam int RESET_CYCLES  = 8;
	localparam int WORD_CYCLES   = 2;
	localparam int TEST_WORDS    = 3 + 28 + 16 + 64 + 200;
	localparam int WATCHDOG_TIME = (RESET_CYCLES + TEST_WORDS * WORD_CYCLES) * 8 + 800;

	logic       Clks, arstN, enT4, isPcRel, isTas;
	nanoWord_t  nanoLatch;
	logic [2:0] auCntrl, aluColumn;
	logic [1:0] aluDctrl;
	dobSel_t    dobCtrl;
	logic       auClkEn, noSpAlign, extDbh, extAbh, todbin, toIrc, ablAbd, ablAbh, dblDbd, dblDbh;
	logic       dbl2Atl, atl2Dbl, abl2Atl, atl2Abl, aob2Ab, updSsw, abh2Ath, dbh2Ath, ath2Dbh;
	logic       ath2Abh, alu2Dbd, alu2Abd, abd2Dcr, dcr2Dbd, dbd2Alue, alue2Dbd, dbd2Alub, abd2Alub;
	logic       au2Db, au2Ab, au2Pc, db2Aob, ab2Aob, au2Aob, dbin2Abd, dbin2Dbd;
	logic       permStart, isWrite, waitBusFinish, busByte, noLowByte, noHighByte, abdIsByte;
	logic       updTpend, clrTpend, tvn2Ftu, const2Ftu, ftu2Dbl, ftu2Abl, inl2psw, pswIToFtu;
	logic       ftu2Sr, sr2Ftu, ird2Ftu, ssw2Ftu, initST, abl2Pren, updPren;
	logic       ir2Ird, aluActrl, aluFinish, aluInit, ftu2Ccr;
	logic       rz, ssp, rxlDbl, reg2dbl, reg2dbh, reg2abl, reg2abh;
	logic       dbl2reg, dbh2reg, abl2reg, abh2reg, pcldbl, pchdbh, pclabl, pchabh;
	logic       rxl2db, rxl2ab, dbl2rxl, abl2rxl, rxh2dbh, rxh2abh, dbh2rxh, abh2rxh;
	logic       dbh2ryh, abh2ryh, dbl2ryl, abl2ryl, ryl2db, ryl2ab, ryh2dbh, ryh2abh, isRmc;

	logic [0:59] regOut;	// T4 registered flags
	logic [0:34] combOut;	// Zero latency flags
	logic [0:59] expReg;
	logic [2:0]  expAuCntrl;
	dobSel_t     expDob;
	integer      seed;

	string regNames [0:59] = '{"auClkEn", "noSpAlign", "extDbh", "extAbh", "todbin", "toIrc",
		"ablAbd", "ablAbh", "dblDbd", "dblDbh", "dbl2Atl", "atl2Dbl", "abl2Atl", "atl2Abl",
		"aob2Ab", "updSsw", "abh2Ath", "dbh2Ath", "ath2Dbh", "ath2Abh", "alu2Dbd", "alu2Abd",
		"abd2Dcr", "dcr2Dbd", "dbd2Alue", "alue2Dbd", "dbd2Alub", "abd2Alub",
		"updTpend", "clrTpend", "tvn2Ftu", "const2Ftu", "ftu2Dbl", "ftu2Abl", "inl2psw",
		"pswIToFtu", "ftu2Sr", "sr2Ftu", "ird2Ftu", "ssw2Ftu", "initST", "abl2Pren", "updPren",
		"rxl2db", "rxl2ab", "dbl2rxl", "abl2rxl", "rxh2dbh", "rxh2abh", "dbh2rxh", "abh2rxh",
		"dbh2ryh", "abh2ryh", "dbl2ryl", "abl2ryl", "ryl2db", "ryl2ab", "ryh2dbh", "ryh2abh",
		"isRmc"};
	string combNames [0:34] = '{"au2Db", "au2Ab", "au2Pc", "db2Aob", "ab2Aob", "au2Aob",
		"dbin2Abd", "dbin2Dbd", "permStart", "isWrite", "waitBusFinish", "busByte",
		"noLowByte", "noHighByte", "abdIsByte", "ir2Ird", "aluActrl", "aluFinish", "aluInit",
		"ftu2Ccr", "rz", "ssp", "rxlDbl", "reg2dbl", "reg2dbh", "reg2abl", "reg2abh",
		"dbl2reg", "dbh2reg", "abl2reg", "abh2reg", "pcldbl", "pchdbh", "pclabl", "pchabh"};

	assign regOut = {auClkEn, noSpAlign, extDbh, extAbh, todbin, toIrc, ablAbd, ablAbh,
		dblDbd, dblDbh, dbl2Atl, atl2Dbl, abl2Atl, atl2Abl, aob2Ab, updSsw, abh2Ath, dbh2Ath,
		ath2Dbh, ath2Abh, alu2Dbd, alu2Abd, abd2Dcr, dcr2Dbd, dbd2Alue, alue2Dbd, dbd2Alub,
		abd2Alub, updTpend, clrTpend, tvn2Ftu, const2Ftu, ftu2Dbl, ftu2Abl, inl2psw, pswIToFtu,
		ftu2Sr, sr2Ftu, ird2Ftu, ssw2Ftu, initST, abl2Pren, updPren, rxl2db, rxl2ab, dbl2rxl,
		abl2rxl, rxh2dbh, rxh2abh, dbh2rxh, abh2rxh, dbh2ryh, abh2ryh, dbl2ryl, abl2ryl,
		ryl2db, ryl2ab, ryh2dbh, ryh2abh, isRmc};
	assign combOut = {au2Db, au2Ab, au2Pc, db2Aob, ab2Aob, au2Aob, dbin2Abd, dbin2Dbd,
		permStart, isWrite, waitBusFinish, busByte, noLowByte, noHighByte, abdIsByte, ir2Ird,
		aluActrl, aluFinish, aluInit, ftu2Ccr, rz, ssp, rxlDbl, reg2dbl, reg2dbh, reg2abl,
		reg2abh, dbl2reg, dbh2reg, abl2reg, abh2reg, pcldbl, pchdbh, pclabl, pchabh};

	nanoDecodeUnit i_nanoDecodeUnit (.*);

	always #4 Clks = ~Clks;

	// PC path strobes in the order pcldbl, pchdbh, pclabl, pchabh
	function automatic logic [0:3] pcPaths(input nanoWord_t w, input logic pcRel);
		logic sub;
		sub = pcRel & ~w[43];	// RZ blocks the substitution
		pcPaths = {w[39] | (sub & ~w[40]), (w[1:0] == 2'b01) | (sub & ~w[22]),
			w[41] | (sub & w[40]), (w[1:0] == 2'b10) | (sub & w[22])};
	endfunction

	// Returns {to RX, to RY} for one transfer bit on one bus
	function automatic logic [1:0] steer(input logic t, input logic busy, input logic rxHere);
		steer = {t & ~busy & rxHere, t & ~busy & ~rxHere};
	endfunction

	function automatic logic [0:34] combModel(input nanoWord_t w, input logic pcRel);
		logic [1:0] au, aob, fi;
		logic       wr;
		au  = w[21:20];
		aob = w[4:3];
		fi  = w[62:61];
		wr  = w[56] | w[53];	// Any DOB source is a write
		combModel = {au == 2'd1, au == 2'd2, au == 2'd3, aob == 2'd2, aob == 2'd1,
			aob == 2'd3, w[46], w[47], aob != 2'd0, wr, w[66] | w[60] | wr, w[42], w[55],
			w[54], w[38], w[67], w[50], fi == 2'd2, fi == 2'd1, fi == 2'd3, w[43], w[24],
			w[40], w[32], w[6], w[37], w[8], w[33], w[5], w[36], w[7], pcPaths(w, pcRel)};
	endfunction

	function automatic logic [0:59] regModel(input nanoWord_t w, input logic pcRel,
		input logic tas);
		logic [2:0]  ath, atl, dcr;
		logic [3:0]  ftu;
		logic [0:14] f;
		logic [0:3]  pc;
		logic [1:0]  sDl, sAl, lDl, lAl, sDh, sAh, lDh, lAh;
		ath = w[11:9];
		atl = w[31:29];
		dcr = w[59:57];
		ftu = {w[25], w[26], w[27], w[28]};	// Field is stored reversed
		pc  = pcPaths(w, pcRel);
		case (ftu)
			4'd1:    f = 15'b10010_00000_00000;	// updTpend and const2Ftu
			4'd2:    f = 15'b00000_00010_00000;
			4'd4:    f = 15'b00001_00000_00000;
			4'd5:    f = 15'b00000_00100_00000;
			4'd6:    f = 15'b00001_01000_00100;	// Inl with ftu2Dbl and initST
			4'd7:    f = 15'b00000_00001_00000;
			4'd8:    f = 15'b00000_10000_00000;
			4'd9:    f = 15'b00000_00000_10000;
			4'd10:   f = 15'b00000_00000_00001;
			4'd11:   f = 15'b00000_00000_01000;
			4'd12:   f = 15'b00000_00000_00010;
			4'd13:   f = 15'b00100_00000_00000;
			4'd14:   f = 15'b01000_00000_00100;
			4'd15:   f = 15'b00000_00000_00100;
			default: f = '0;
		endcase
		sDl = steer(w[32], pc[0], w[40]);
		sAl = steer(w[37], pc[2], ~w[40]);
		lDl = steer(w[33], pc[0], w[40]);
		lAl = steer(w[36], pc[2], ~w[40]);
		sDh = steer(w[6], pc[1], w[22]);
		sAh = steer(w[8], pc[3], ~w[22]);
		lDh = steer(w[5], pc[1], w[22]);
		lAh = steer(w[7], pc[3], ~w[22]);
		regModel = {~w[19], w[1:0] == 2'b11, w[12], w[13], w[60], w[66], w[35], w[14], w[34],
			w[15], atl == 3'd2, atl == 3'd3, atl == 3'd4, atl == 3'd5, ath == 3'd5,
			ath == 3'd5, ath == 3'd1 || ath == 3'd5, ath == 3'd4, ath == 3'd6, ath == 3'd3,
			w[44], w[45], dcr[1:0] == 2'b11, dcr[2:1] == 2'b11, dcr[2:1] == 2'b10,
			dcr[1:0] == 2'b01, w[49], w[48], f,
			sDl[1], sAl[1], lDl[1], lAl[1], sDh[1], sAh[1], lDh[1], lAh[1],
			lDh[0], lAh[0], lDl[0], lAl[0], sDl[0], sAl[0], sDh[0], sAh[0], tas & w[42]};
	endfunction

	task automatic stopOnError(input string why);
		$display("%s", why);
		$display("SIMULATION FAILED");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic checkFlag(input logic got, input logic exp, input string name);
		if (got !== exp) begin
			stopOnError($sformatf("Mismatch at %0t: %s is %b, expected %b", $time, name, got, exp));
		end
	endtask

	task automatic checkField3(input logic [2:0] got, input logic [2:0] exp, input string name);
		if (got !== exp) begin
			stopOnError($sformatf("Mismatch at %0t: %s is %b, expected %b", $time, name, got, exp));
		end
	endtask

	task automatic checkField2(input logic [1:0] got, input logic [1:0] exp, input string name);
		if (got !== exp) begin
			stopOnError($sformatf("Mismatch at %0t: %s is %b, expected %b", $time, name, got, exp));
		end
	endtask

	task automatic checkDob(input dobSel_t got, input dobSel_t exp, input string name);
		if (got !== exp) begin
			stopOnError($sformatf("Mismatch at %0t: %s is %s, expected %s", $time, name,
				got.name(), exp.name()));
		end
	endtask

	task automatic checkAll();
		logic [0:34] combExp;
		nanoWord_t   w;
		w       = nanoLatch;
		combExp = combModel(w, isPcRel);
		for (int i = 0; i < 60; i++) begin
			checkFlag(regOut[i], expReg[i], regNames[i]);
		end
		for (int i = 0; i < 35; i++) begin
			checkFlag(combOut[i], combExp[i], combNames[i]);
		end
		checkField3(auCntrl, expAuCntrl, "auCntrl");
		checkField3(aluColumn, {w[63], w[64], w[65]}, "aluColumn");
		checkField2(aluDctrl, w[52:51], "aluDctrl");
		checkDob(dobCtrl, expDob, "dobCtrl");
	endtask

	// Checks before the T4 edge too, so combinational paths show zero latency
	task automatic applyWord(input nanoWord_t w, input logic pcRel, input logic tas,
		input logic pulse);
		@(posedge Clks);
		nanoLatch <= w;
		isPcRel   <= pcRel;
		isTas     <= tas;
		enT4      <= pulse;
		@(negedge Clks);
		checkAll();
		@(posedge Clks);
		enT4 <= 1'b0;
		if (pulse) begin
			expReg     = regModel(w, pcRel, tas);
			expAuCntrl = w[18:16];
			expDob     = dobSel_t'({w[56], w[53]});
		end
		@(negedge Clks);
		checkAll();
	endtask

	task automatic resetTest();
		repeat (5) begin
			@(negedge Clks);
			checkAll();
		end
		@(posedge Clks);
		arstN <= 1'b1;
		repeat (2) begin
			@(negedge Clks);
			checkAll();	// No T4 yet, registers stay clear
		end
	endtask

	task automatic latencyTest();
		nanoWord_t w;
		w = '0;
		applyWord(w, 1'b0, 1'b0, 1'b1);
		w[21:20] = 2'b11;	// au2Pc
		w[4:3]   = 2'b01;	// permStart
		w[62:61] = 2'b01;	// aluInit
		w[11:9]  = 3'd3;
		w[18:16] = 3'd5;
		w[25]    = 1'b1;	// FTU code 9
		w[28]    = 1'b1;
		w[56]    = 1'b1;
		applyWord(w, 1'b0, 1'b0, 1'b0);
		applyWord(w, 1'b0, 1'b0, 1'b1);
	endtask

	task automatic tempRegSweep();
		nanoWord_t w;
		for (int c = 0; c < 8; c++) begin
			w        = '0;
			w[11:9]  = c[2:0];
			applyWord(w, 1'b0, 1'b0, 1'b1);
			w        = '0;
			w[31:29] = c[2:0];
			applyWord(w, 1'b0, 1'b0, 1'b1);
			w        = '0;
			w[59:57] = c[2:0];	// DCR and ALUE share these bits
			applyWord(w, 1'b0, 1'b0, 1'b1);
		end
		for (int c = 0; c < 4; c++) begin
			w     = '0;
			w[56] = c[1];
			w[53] = c[0];
			applyWord(w, 1'b0, 1'b0, 1'b1);
		end
	endtask

	task automatic ftuSweep();
		nanoWord_t  w;
		logic [3:0] code;
		for (int c = 0; c < 16; c++) begin
			code  = c[3:0];
			w     = '0;
			w[25] = code[3];
			w[26] = code[2];
			w[27] = code[1];
			w[28] = code[0];
			applyWord(w, 1'b0, 1'b0, 1'b1);
		end
	endtask

	task automatic pcRelTest();
		nanoWord_t w;
		for (int k = 0; k < 64; k++) begin
			w     = '0;
			w[32] = 1'b1;
			w[37] = 1'b1;
			w[33] = 1'b1;
			w[36] = 1'b1;
			w[6]  = 1'b1;
			w[8]  = 1'b1;
			w[5]  = 1'b1;
			w[7]  = 1'b1;
			w[43] = k[0];	// rz
			w[40] = k[1];
			w[22] = k[2];
			w[42] = k[3];	// busByte
			applyWord(w, k[4], k[5], 1'b1);
		end
	endtask

	task automatic randomTest();
		logic [95:0] r;
		logic [1:0]  flags;
		for (int n = 0; n < 200; n++) begin
			r     = {$random(seed), $random(seed), $random(seed)};
			flags = $random(seed);
			applyWord(r[67:0], flags[0], flags[1], 1'b1);
		end
	endtask

	initial begin
		#(WATCHDOG_TIME);
		stopOnError("Timeout: the directed tests did not complete in the expected time");
	end

	initial begin
		Clks       = 1'b0;
		arstN      = 1'b0;
		enT4       = 1'b0;
		nanoLatch  = '1;	// All ones must not leak into registers during reset
		isPcRel    = 1'b1;
		isTas      = 1'b1;
		seed       = 32'ha1be53fc;
		expReg     = '0;
		expAuCntrl = 3'd0;
		expDob     = None;
		resetTest();
		latencyTest();
		tempRegSweep();
		ftuSweep();
		pcRelTest();
		randomTest();
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

//--- nanoDecodeUnit.sv
// Nanocode decode stage turning the latched nanoword into datapath strobes
module nanoDecodeUnit
	import nanoDecodePkg::*;
(
	input  logic       Clks,
	input  logic       arstN,
	input  logic       enT4,
	input  nanoWord_t  nanoLatch,
	input  logic       isPcRel,
	input  logic       isTas,
	// Bus transfer strobes
	output logic       auClkEn,
	output logic [2:0] auCntrl,
	output logic       noSpAlign, extDbh, extAbh, todbin, toIrc,
	output logic       ablAbd, ablAbh, dblDbd, dblDbh,
	output logic       dbl2Atl, atl2Dbl, abl2Atl, atl2Abl,
	output logic       aob2Ab, updSsw,
	output logic       abh2Ath, dbh2Ath, ath2Dbh, ath2Abh,
	output logic       alu2Dbd, alu2Abd,
	output logic       abd2Dcr, dcr2Dbd, dbd2Alue, alue2Dbd,
	output logic       dbd2Alub, abd2Alub,
	output dobSel_t    dobCtrl,
	output logic       au2Db, au2Ab, au2Pc,
	output logic       db2Aob, ab2Aob, au2Aob,
	output logic       dbin2Abd, dbin2Dbd,
	output logic       permStart, isWrite, waitBusFinish,
	output logic       busByte, noLowByte, noHighByte, abdIsByte,
	// FTU and ALU sequencing
	output logic       updTpend, clrTpend, tvn2Ftu, const2Ftu,
	output logic       ftu2Dbl, ftu2Abl, inl2psw, pswIToFtu,
	output logic       ftu2Sr, sr2Ftu, ird2Ftu, ssw2Ftu,
	output logic       initST, abl2Pren, updPren,
	output logic       ir2Ird,
	output logic [1:0] aluDctrl,
	output logic       aluActrl,
	output logic [2:0] aluColumn,
	output logic       aluFinish, aluInit, ftu2Ccr,
	// Register routing
	output logic       rz, ssp, rxlDbl,
	output logic       reg2dbl, reg2dbh, reg2abl, reg2abh,
	output logic       dbl2reg, dbh2reg, abl2reg, abh2reg,
	output logic       pcldbl, pchdbh, pclabl, pchabh,
	output logic       rxl2db, rxl2ab, dbl2rxl, abl2rxl,
	output logic       rxh2dbh, rxh2abh, dbh2rxh, abh2rxh,
	output logic       dbh2ryh, abh2ryh, dbl2ryl, abl2ryl,
	output logic       ryl2db, ryl2ab, ryh2dbh, ryh2abh,
	output logic       isRmc
);

	logic [1:0] pchField;	// Raw PC-high field into the router

	nanoBusDecode i_nanoBusDecode (
		.*
	);

	nanoFtuDecode i_nanoFtuDecode (
		.*
	);

	nanoRegRoute i_nanoRegRoute (
		.*
	);

endmodule

//--- nanoRegRoute.sv
// PC substitution and RX/RY register routing with the read-modify-write flag
`include "nanoDecode_config.svh"

module nanoRegRoute
	import nanoDecodePkg::*;
(
	input  logic       Clks,
	input  logic       arstN,
	input  logic       enT4,
	input  nanoWord_t  nanoLatch,
	input  logic       isPcRel,
	input  logic       isTas,
	input  logic [1:0] pchField,
	output logic       rz, ssp, rxlDbl,
	output logic       reg2dbl, reg2dbh, reg2abl, reg2abh,
	output logic       dbl2reg, dbh2reg, abl2reg, abh2reg,
	output logic       pcldbl, pchdbh, pclabl, pchabh,
	output logic       rxl2db, rxl2ab, dbl2rxl, abl2rxl,
	output logic       rxh2dbh, rxh2abh, dbh2rxh, abh2rxh,
	output logic       dbh2ryh, abh2ryh, dbl2ryl, abl2ryl,
	output logic       ryl2db, ryl2ab, ryh2dbh, ryh2abh,
	output logic       isRmc
);

	logic rxhDbh;
	logic pcRel;
	logic pcRelDbl, pcRelDbh, pcRelAbl, pcRelAbh;

	// Raw register transfer bits, combined with IRD only at T4
	assign abl2reg = nanoLatch[`NANO_ABL2REG];
	assign abh2reg = nanoLatch[`NANO_ABH2REG];
	assign dbl2reg = nanoLatch[`NANO_DBL2REG];
	assign dbh2reg = nanoLatch[`NANO_DBH2REG];
	assign reg2dbl = nanoLatch[`NANO_REG2DBL];
	assign reg2dbh = nanoLatch[`NANO_REG2DBH];
	assign reg2abl = nanoLatch[`NANO_REG2ABL];
	assign reg2abh = nanoLatch[`NANO_REG2ABH];
	assign ssp     = nanoLatch[`NANO_SSP];
	assign rz      = nanoLatch[`NANO_RZ];
	assign rxlDbl  = nanoLatch[`NANO_RXL_DBL];
	assign rxhDbh  = nanoLatch[`NANO_RXH_DBH];

	// PC takes the place of RY on PC-relative modes
	assign pcRel    = isPcRel & ~rz;
	assign pcRelDbl = pcRel & ~rxlDbl;
	assign pcRelDbh = pcRel & ~rxhDbh;
	assign pcRelAbl = pcRel & rxlDbl;
	assign pcRelAbh = pcRel & rxhDbh;

	assign pcldbl = nanoLatch[`NANO_PCLDBL] | pcRelDbl;
	assign pchdbh = (pchField == `NANO_PCH_DBH) | pcRelDbh;
	assign pclabl = nanoLatch[`NANO_PCLABL] | pcRelAbl;
	assign pchabh = (pchField == `NANO_PCH_ABH) | pcRelAbh;

	always_ff @(posedge Clks or negedge arstN) begin
		if (!arstN) begin
			rxl2db  <= 1'b0;
			rxl2ab  <= 1'b0;
			dbl2rxl <= 1'b0;
			abl2rxl <= 1'b0;
			rxh2dbh <= 1'b0;
			rxh2abh <= 1'b0;
			dbh2rxh <= 1'b0;
			abh2rxh <= 1'b0;
			dbh2ryh <= 1'b0;
			abh2ryh <= 1'b0;
			dbl2ryl <= 1'b0;
			abl2ryl <= 1'b0;
			ryl2db  <= 1'b0;
			ryl2ab  <= 1'b0;
			ryh2dbh <= 1'b0;
			ryh2abh <= 1'b0;
			isRmc   <= 1'b0;
		end else if (enT4) begin
			// RX side, blocked when a PC path owns the bus
			rxl2db  <= reg2dbl & ~pcldbl & rxlDbl;
			rxl2ab  <= reg2abl & ~pclabl & ~rxlDbl;
			dbl2rxl <= dbl2reg & ~pcldbl & rxlDbl;
			abl2rxl <= abl2reg & ~pclabl & ~rxlDbl;
			rxh2dbh <= reg2dbh & ~pchdbh & rxhDbh;
			rxh2abh <= reg2abh & ~pchabh & ~rxhDbh;
			dbh2rxh <= dbh2reg & ~pchdbh & rxhDbh;
			abh2rxh <= abh2reg & ~pchabh & ~rxhDbh;
			// RY side takes the other bus
			dbh2ryh <= dbh2reg & ~pchdbh & ~rxhDbh;
			abh2ryh <= abh2reg & ~pchabh & rxhDbh;
			dbl2ryl <= dbl2reg & ~pcldbl & ~rxlDbl;
			abl2ryl <= abl2reg & ~pclabl & rxlDbl;
			ryl2db  <= reg2dbl & ~pcldbl & ~rxlDbl;
			ryl2ab  <= reg2abl & ~pclabl & rxlDbl;
			ryh2dbh <= reg2dbh & ~pchdbh & ~rxhDbh;
			ryh2abh <= reg2abh & ~pchabh & rxhDbh;
			isRmc   <= isTas & nanoLatch[`NANO_BUSBYTE];	// TAS locks the bus
		end
	end

	// RXL and RYL never drive DBL in the same word
	dblSingleDriver: assert property (@(posedge Clks) disable iff (!arstN)
		!(rxl2db && ryl2db));

endmodule

//--- nanoFtuDecode.sv
// Field translation unit control latch and ALU sequencing decode
`include "nanoDecode_config.svh"

module nanoFtuDecode
	import nanoDecodePkg::*;
(
	input  logic       Clks,
	input  logic       arstN,
	input  logic       enT4,
	input  nanoWord_t  nanoLatch,
	output logic       updTpend, clrTpend, tvn2Ftu, const2Ftu,
	output logic       ftu2Dbl, ftu2Abl, inl2psw, pswIToFtu,
	output logic       ftu2Sr, sr2Ftu, ird2Ftu, ssw2Ftu,
	output logic       initST, abl2Pren, updPren,
	output logic       ir2Ird,
	output logic [1:0] aluDctrl,
	output logic       aluActrl,
	output logic [2:0] aluColumn,
	output logic       aluFinish, aluInit, ftu2Ccr
);

	ftuOp_t     ftuCtrl;
	logic [3:0] ftuField;
	logic [1:0] aluFinInit;

	// Nanorom holds the FTU field in reverse bit order
	assign ftuField = {nanoLatch[`NANO_FTUCONTROL],   nanoLatch[`NANO_FTUCONTROL+1],
		nanoLatch[`NANO_FTUCONTROL+2], nanoLatch[`NANO_FTUCONTROL+3]};

	always_ff @(posedge Clks or negedge arstN) begin
		if (!arstN) begin
			ftuCtrl <= Idle;
		end else if (enT4) begin
			ftuCtrl <= ftuOp_t'(ftuField);
		end
	end

	assign updTpend  = (ftuCtrl == UpdTpend);
	assign const2Ftu = (ftuCtrl == ftuOp_t'(`NANO_FTU_CONST));	// Constant comes from IRD
	assign clrTpend  = (ftuCtrl == ClrTpend);
	assign tvn2Ftu   = (ftuCtrl == Tvn);
	assign ftu2Dbl   = (ftuCtrl == Dbl) | (ftuCtrl == Inl);
	assign ftu2Abl   = (ftuCtrl == Ftu2Abl);
	assign inl2psw   = (ftuCtrl == Inl);
	assign pswIToFtu = (ftuCtrl == PswI);
	assign ftu2Sr    = (ftuCtrl == Ftu2Sr);
	assign sr2Ftu    = (ftuCtrl == RdSr);
	assign ird2Ftu   = (ftuCtrl == Ird);
	assign ssw2Ftu   = (ftuCtrl == Ssw);
	assign abl2Pren  = (ftuCtrl == Abl2Pren);
	assign updPren   = (ftuCtrl == RstPren);

	// Set S and clear T, TPEND untouched except by ClrTpend
	assign initST = (ftuCtrl == Inl) | (ftuCtrl == ClrTpend) | (ftuCtrl == InitSt);

	assign ir2Ird = nanoLatch[`NANO_IR2IRD];

	// ALU controls stay combinational and are merged with IRD later
	assign aluDctrl  = nanoLatch[`NANO_ALU_DCTRL+1:`NANO_ALU_DCTRL];
	assign aluActrl  = nanoLatch[`NANO_ALU_ACTRL];
	assign aluColumn = {nanoLatch[`NANO_ALU_COL], nanoLatch[`NANO_ALU_COL+1],
		nanoLatch[`NANO_ALU_COL+2]};

	assign aluFinInit = nanoLatch[`NANO_ALU_FI+1:`NANO_ALU_FI];
	assign aluFinish  = (aluFinInit == `NANO_ALUFI_FINISH);
	assign aluInit    = (aluFinInit == `NANO_ALUFI_INIT);
	assign ftu2Ccr    = (aluFinInit == `NANO_ALUFI_CCR);	// Both bits set writes CCR only

	// FTU code moves only on edges that sampled a T4 strobe
	ftuLoadOnT4: assert property (@(posedge Clks) disable iff (!arstN)
		!$past(enT4) |-> $stable(ftuCtrl));

endmodule

//--- nanoBusDecode.sv
// Bus transfer decoder for temp registers, address unit, ALU extension, DCR and output buffers
`include "nanoDecode_config.svh"

module nanoBusDecode
	import nanoDecodePkg::*;
(
	input  logic       Clks,
	input  logic       arstN,
	input  logic       enT4,
	input  nanoWord_t  nanoLatch,
	output logic       auClkEn,
	output logic [2:0] auCntrl,
	output logic       noSpAlign, extDbh, extAbh, todbin, toIrc,
	output logic       ablAbd, ablAbh, dblDbd, dblDbh,
	output logic       dbl2Atl, atl2Dbl, abl2Atl, atl2Abl,
	output logic       aob2Ab, updSsw,
	output logic       abh2Ath, dbh2Ath, ath2Dbh, ath2Abh,
	output logic       alu2Dbd, alu2Abd,
	output logic       abd2Dcr, dcr2Dbd, dbd2Alue, alue2Dbd,
	output logic       dbd2Alub, abd2Alub,
	output dobSel_t    dobCtrl,
	output logic       au2Db, au2Ab, au2Pc,
	output logic       db2Aob, ab2Aob, au2Aob,
	output logic       dbin2Abd, dbin2Dbd,
	output logic       permStart, isWrite, waitBusFinish,
	output logic       busByte, noLowByte, noHighByte, abdIsByte,
	output logic [1:0] pchField
);

	athOp_t     athCtrl;
	atlOp_t     atlCtrl;
	auOut_t     auSel;
	aobSel_t    aobSel;
	dobSel_t    dobSel;
	logic [2:0] dcrField;
	logic [2:0] alueField;

	assign athCtrl   = athOp_t'(nanoLatch[`NANO_ATHCTRL+2:`NANO_ATHCTRL]);
	assign atlCtrl   = atlOp_t'(nanoLatch[`NANO_ATLCTRL+2:`NANO_ATLCTRL]);
	assign auSel     = auOut_t'(nanoLatch[`NANO_AUOUT+1:`NANO_AUOUT]);
	assign aobSel    = aobSel_t'(nanoLatch[`NANO_AOBCTRL+1:`NANO_AOBCTRL]);
	assign dobSel    = dobSel_t'({nanoLatch[`NANO_DOBCTRL_1], nanoLatch[`NANO_DOBCTRL_0]});
	assign dcrField  = nanoLatch[`NANO_DCR+2:`NANO_DCR];
	assign alueField = nanoLatch[`NANO_ALUE+2:`NANO_ALUE];	// Shares bits with DCR
	assign pchField  = nanoLatch[`NANO_PCH+1:`NANO_PCH];

	always_ff @(posedge Clks or negedge arstN) begin
		if (!arstN) begin
			auClkEn   <= 1'b0;
			auCntrl   <= 3'd0;
			noSpAlign <= 1'b0;
			extDbh    <= 1'b0;
			extAbh    <= 1'b0;
			todbin    <= 1'b0;
			toIrc     <= 1'b0;
			ablAbd    <= 1'b0;
			ablAbh    <= 1'b0;
			dblDbd    <= 1'b0;
			dblDbh    <= 1'b0;
			dbl2Atl   <= 1'b0;
			atl2Dbl   <= 1'b0;
			abl2Atl   <= 1'b0;
			atl2Abl   <= 1'b0;
			aob2Ab    <= 1'b0;
			abh2Ath   <= 1'b0;
			dbh2Ath   <= 1'b0;
			ath2Dbh   <= 1'b0;
			ath2Abh   <= 1'b0;
			alu2Dbd   <= 1'b0;
			alu2Abd   <= 1'b0;
			abd2Dcr   <= 1'b0;
			dcr2Dbd   <= 1'b0;
			dbd2Alue  <= 1'b0;
			alue2Dbd  <= 1'b0;
			dbd2Alub  <= 1'b0;
			abd2Alub  <= 1'b0;
			dobCtrl   <= None;
		end else if (enT4) begin
			auClkEn   <= ~nanoLatch[`NANO_AUCLKEN];	// Word bit is a clock disable
			auCntrl   <= nanoLatch[`NANO_AUCTRL+2:`NANO_AUCTRL];
			noSpAlign <= (pchField == `NANO_PCH_NOALIGN);
			extDbh    <= nanoLatch[`NANO_EXT_DBH];
			extAbh    <= nanoLatch[`NANO_EXT_ABH];
			todbin    <= nanoLatch[`NANO_TODBIN];
			toIrc     <= nanoLatch[`NANO_TOIRC];
			ablAbd    <= nanoLatch[`NANO_ABLABD];
			ablAbh    <= nanoLatch[`NANO_ABLABH];
			dblDbd    <= nanoLatch[`NANO_DBLDBD];
			dblDbh    <= nanoLatch[`NANO_DBLDBH];
			dbl2Atl   <= (atlCtrl == DblToAtl);
			atl2Dbl   <= (atlCtrl == AtlToDbl);
			abl2Atl   <= (atlCtrl == AblToAtl);
			atl2Abl   <= (atlCtrl == AtlToAbl);
			aob2Ab    <= (athCtrl == AobToAb);	// Bus error entry only
			abh2Ath   <= (athCtrl == AbhToAth) | (athCtrl == AobToAb);
			dbh2Ath   <= (athCtrl == DbhToAth);
			ath2Dbh   <= (athCtrl == AthToDbh);
			ath2Abh   <= (athCtrl == AthToAbh);
			alu2Dbd   <= nanoLatch[`NANO_ALU2DBD];
			alu2Abd   <= nanoLatch[`NANO_ALU2ABD];
			abd2Dcr   <= (dcrField[1:0] == `NANO_DCR_LOAD);
			dcr2Dbd   <= (dcrField[2:1] == `NANO_DCR_READ);
			dbd2Alue  <= (alueField[2:1] == `NANO_ALUE_LOAD);
			alue2Dbd  <= (alueField[1:0] == `NANO_ALUE_READ);
			dbd2Alub  <= nanoLatch[`NANO_DBD2ALUB];
			abd2Alub  <= nanoLatch[`NANO_ABD2ALUB];
			dobCtrl   <= dobSel;	// Output buffer loads a cycle later, at T3
		end
	end

	// SSW update opens the bus/address error routine
	assign updSsw = aob2Ab;

	assign au2Db  = (auSel == AuToDb);
	assign au2Ab  = (auSel == AuToAb);
	assign au2Pc  = (auSel == AuToPc);
	assign db2Aob = (aobSel == AobDb);
	assign ab2Aob = (aobSel == AobAb);
	assign au2Aob = (aobSel == AobAu);

	assign dbin2Abd = nanoLatch[`NANO_DBIN2ABD];
	assign dbin2Dbd = nanoLatch[`NANO_DBIN2DBD];

	assign permStart     = (aobSel != AobIdle);
	assign isWrite       = (dobSel != None);
	assign waitBusFinish = nanoLatch[`NANO_TOIRC] | nanoLatch[`NANO_TODBIN] | isWrite;
	assign busByte       = nanoLatch[`NANO_BUSBYTE];
	assign noLowByte     = nanoLatch[`NANO_LOWBYTE];	// MOVEP byte lanes
	assign noHighByte    = nanoLatch[`NANO_HIGHBYTE];
	assign abdIsByte     = nanoLatch[`NANO_ABDHRECHARGE];

	// Only one ATL transfer may be latched per T4 word
	atlStrobeOneHot: assert property (@(posedge Clks) disable iff (!arstN)
		$onehot0({dbl2Atl, atl2Dbl, abl2Atl, atl2Abl}));

endmodule

//--- nanoDecodePkg.sv
// Nanoword type and field code enums shared by the nanocode decoders
`include "nanoDecode_config.svh"

package nanoDecodePkg;

	typedef logic [`NANO_WIDTH-1:0] nanoWord_t;

	// Code 1 serves both UpdTpend and Const2Ftu
	typedef enum logic [3:0] {
		Idle     = `NANO_FTU_IDLE,
		UpdTpend = `NANO_FTU_UPDTPEND,
		Ftu2Sr   = `NANO_FTU_2SR,
		Dbl      = `NANO_FTU_DBL,
		PswI     = `NANO_FTU_PSWI,
		Inl      = `NANO_FTU_INL,
		RdSr     = `NANO_FTU_RDSR,
		Ftu2Abl  = `NANO_FTU_2ABL,
		Ird      = `NANO_FTU_IRD,
		RstPren  = `NANO_FTU_RSTPREN,
		Ssw      = `NANO_FTU_SSW,
		Abl2Pren = `NANO_FTU_ABL2PREN,
		Tvn      = `NANO_FTU_TVN,
		ClrTpend = `NANO_FTU_CLRTPEND,
		InitSt   = `NANO_FTU_INIT_ST
	} ftuOp_t;

	typedef enum logic [2:0] {
		AthIdle  = `NANO_ATH_IDLE,
		AbhToAth = `NANO_ATH_ABH2ATH,
		AthToAbh = `NANO_ATH_ATH2ABH,
		DbhToAth = `NANO_ATH_DBH2ATH,
		AobToAb  = `NANO_ATH_AOB2AB,
		AthToDbh = `NANO_ATH_ATH2DBH
	} athOp_t;

	typedef enum logic [2:0] {
		AtlIdle  = `NANO_ATL_IDLE,
		DblToAtl = `NANO_ATL_DBL2ATL,
		AtlToDbl = `NANO_ATL_ATL2DBL,
		AblToAtl = `NANO_ATL_ABL2ATL,
		AtlToAbl = `NANO_ATL_ATL2ABL
	} atlOp_t;

	typedef enum logic [1:0] {AuIdle = `NANO_AU_IDLE, AuToDb = `NANO_AU_DB,
		AuToAb = `NANO_AU_AB, AuToPc = `NANO_AU_PC} auOut_t;

	typedef enum logic [1:0] {AobIdle = `NANO_AOB_IDLE, AobAb = `NANO_AOB_AB,
		AobDb = `NANO_AOB_DB, AobAu = `NANO_AOB_AU} aobSel_t;

	typedef enum logic [1:0] {None = `NANO_DOB_NONE, Dbd = `NANO_DOB_DBD,
		Adb = `NANO_DOB_ADB, Alu = `NANO_DOB_ALU} dobSel_t;

endpackage

//--- nanoDecode_config.svh
// Nanoword layout and field codes for the nanocode decode stage
`ifndef NANODECODE_CONFIG_SVH
`define NANODECODE_CONFIG_SVH

`define NANO_WIDTH 68

// Field positions, lowest bit of each field
`define NANO_IR2IRD       67
`define NANO_TOIRC        66
`define NANO_ALU_COL      63	// Column bits read 63-64-65
`define NANO_ALU_FI       61	// Finish/init, 62-61
`define NANO_TODBIN       60
`define NANO_ALUE         57	// 59-57, same bits as DCR
`define NANO_DCR          57
`define NANO_DOBCTRL_1    56
`define NANO_LOWBYTE      55
`define NANO_HIGHBYTE     54
`define NANO_DOBCTRL_0    53
`define NANO_ALU_DCTRL    51	// 52-51
`define NANO_ALU_ACTRL    50
`define NANO_DBD2ALUB     49
`define NANO_ABD2ALUB     48
`define NANO_DBIN2DBD     47
`define NANO_DBIN2ABD     46
`define NANO_ALU2ABD      45
`define NANO_ALU2DBD      44
`define NANO_RZ           43
`define NANO_BUSBYTE      42
`define NANO_PCLABL       41
`define NANO_RXL_DBL      40	// Swaps RXL and RYL between DBL and ABL
`define NANO_PCLDBL       39
`define NANO_ABDHRECHARGE 38
`define NANO_REG2ABL      37
`define NANO_ABL2REG      36
`define NANO_ABLABD       35
`define NANO_DBLDBD       34
`define NANO_DBL2REG      33
`define NANO_REG2DBL      32
`define NANO_ATLCTRL      29	// 31-29
`define NANO_FTUCONTROL   25	// 28-25, stored reversed
`define NANO_SSP          24
`define NANO_RXH_DBH      22	// Swaps RXH and RYH between DBH and ABH
`define NANO_AUOUT        20	// 21-20
`define NANO_AUCLKEN      19	// Active low in the word
`define NANO_AUCTRL       16	// 18-16
`define NANO_DBLDBH       15
`define NANO_ABLABH       14
`define NANO_EXT_ABH      13
`define NANO_EXT_DBH      12
`define NANO_ATHCTRL      9	// 11-9
`define NANO_REG2ABH      8
`define NANO_ABH2REG      7
`define NANO_REG2DBH      6
`define NANO_DBH2REG      5
`define NANO_AOBCTRL      3	// 4-3
`define NANO_PCH          0	// 1-0

// FTU operation codes, after bit reversal
`define NANO_FTU_IDLE     4'd0
`define NANO_FTU_UPDTPEND 4'd1	// Also loads the FTU constant
`define NANO_FTU_CONST    4'd1
`define NANO_FTU_2SR      4'd2
`define NANO_FTU_DBL      4'd4
`define NANO_FTU_PSWI     4'd5
`define NANO_FTU_INL      4'd6
`define NANO_FTU_RDSR     4'd7
`define NANO_FTU_2ABL     4'd8
`define NANO_FTU_IRD      4'd9
`define NANO_FTU_RSTPREN  4'd10
`define NANO_FTU_SSW      4'd11
`define NANO_FTU_ABL2PREN 4'd12
`define NANO_FTU_TVN      4'd13
`define NANO_FTU_CLRTPEND 4'd14
`define NANO_FTU_INIT_ST  4'd15

// Temporary register codes
`define NANO_ATH_IDLE     3'd0
`define NANO_ATH_ABH2ATH  3'd1
`define NANO_ATH_ATH2ABH  3'd3
`define NANO_ATH_DBH2ATH  3'd4
`define NANO_ATH_AOB2AB   3'd5	// Also loads ATH from ABH
`define NANO_ATH_ATH2DBH  3'd6
`define NANO_ATL_IDLE     3'd0
`define NANO_ATL_DBL2ATL  3'd2
`define NANO_ATL_ATL2DBL  3'd3
`define NANO_ATL_ABL2ATL  3'd4
`define NANO_ATL_ATL2ABL  3'd5

// Two-bit field codes
`define NANO_AU_IDLE      2'd0
`define NANO_AU_DB        2'd1
`define NANO_AU_AB        2'd2
`define NANO_AU_PC        2'd3
`define NANO_AOB_IDLE     2'd0
`define NANO_AOB_AB       2'd1
`define NANO_AOB_DB       2'd2
`define NANO_AOB_AU       2'd3
`define NANO_DOB_NONE     2'd0
`define NANO_DOB_DBD      2'd1
`define NANO_DOB_ADB      2'd2
`define NANO_DOB_ALU      2'd3
`define NANO_DCR_LOAD     2'b11	// Bits 58-57
`define NANO_DCR_READ     2'b11	// Bits 59-58
`define NANO_ALUE_LOAD    2'b10	// Bits 59-58
`define NANO_ALUE_READ    2'b01	// Bits 58-57
`define NANO_ALUFI_INIT   2'b01
`define NANO_ALUFI_FINISH 2'b10
`define NANO_ALUFI_CCR    2'b11
`define NANO_PCH_DBH      2'b01
`define NANO_PCH_ABH      2'b10
`define NANO_PCH_NOALIGN  2'b11	// Both set means no SP alignment

`endif
